// ==== compile.f ====
source/m92_pkg.sv
source/rom_word_packer.sv
source/sdram_ch3_arbiter.sv
source/dip_switch_bank.sv
source/arcade_inputs.sv
source/m92_mem_ctrl.sv
bench/sdram_model.sv
bench/tb_m92_mem_ctrl.sv

// ==== Bender.yml ====
package:
  name: m92_mem_ctrl

sources:
  - files:
      - source/m92_pkg.sv
      - source/rom_word_packer.sv
      - source/sdram_ch3_arbiter.sv
      - source/dip_switch_bank.sv
      - source/arcade_inputs.sv
      - source/m92_mem_ctrl.sv
  - target: simulation
    files:
      - bench/sdram_model.sv
      - bench/tb_m92_mem_ctrl.sv

// ==== bench/tb_m92_mem_ctrl.sv ====
/* Testbench for the memory and control top with an SDRAM model,
   reference functions for ROM words and merged inputs, and checks */
`timescale 1ns/10ps

module tb_m92_mem_ctrl import m92_pkg::*; ();

    typedef struct packed {
        player_t    p1;
        player_t    p2;
        player_t    p3;
        player_t    p4;
        logic [3:0] start_buttons;
        logic [3:0] coin;
        logic       pause_req;
    } inputs_t;

    logic        clk_sys;
    logic        rst;
    logic        ioctl_download;
    dl_index_t   ioctl_index;
    logic        ioctl_wr;
    byte_addr_t  ioctl_addr;
    ioctl_byte_t ioctl_dout;
    logic        ioctl_wait;
    logic        load_busy;
    word_addr_t  cpu_addr;
    logic        cpu_req;
    logic        cpu_rdy;
    sdr_word_t   cpu_dout;
    sdr_req_t    sdr;
    logic        sdr_rdy;
    sdr_word_t   sdr_dout;
    logic [DIP_OUT_BYTES*8-1:0] dip_sw;
    pad_t        joy_p1;
    pad_t        joy_p2;
    pad_t        joy_p3;
    pad_t        joy_p4;
    pad_t        key_p1;
    pad_t        key_p2;
    pad_t        key_p3;
    pad_t        key_p4;
    logic [3:0]  key_start;
    logic [3:0]  key_coin;
    logic        key_pause;
    player_t     p1_input;
    player_t     p2_input;
    player_t     p3_input;
    player_t     p4_input;
    logic [3:0]  start_buttons;
    logic [3:0]  coin;
    logic        pause_req;

    int          seed;
    int          errors;
    int          checks;
    int          reads_done;
    int          n_rom;
    ioctl_byte_t rom_bytes [64];
    ioctl_byte_t dip_bytes [8];
    sdr_word_t   init_mem [256];
    inputs_t     exp_in;

    m92_mem_ctrl m92_mem_ctrl_inst (.*);
    sdram_model sdram_model_inst (.*);

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference functions and helpers
    ////////////////////////////////////////////////////////////////////////////

    // Little-endian byte pairing over the model's initial contents
    function automatic sdr_word_t ref_word(input word_addr_t wa);
        sdr_word_t w;
        int        lo;
        w  = init_mem[wa[7:0]];
        lo = 2 * int'(wa);
        if (lo < n_rom) w[7:0] = rom_bytes[lo];
        if (lo + 1 < n_rom) w[15:8] = rom_bytes[lo + 1];
        return w;
    endfunction

    function automatic inputs_t ref_inputs(input pad_t j1, j2, j3, j4, k1, k2, k3, k4,
                                           input logic [3:0] ks, kc, input logic kp);
        inputs_t r;
        pad_t    any;
        any = j1 | j2 | j3 | j4;
        r.p1 = player_t'(j1 | k1);
        r.p2 = player_t'(j2 | k2);
        r.p3 = player_t'(j3 | k3);
        r.p4 = player_t'(j4 | k4);
        r.start_buttons = {j4[BTN_START] | ks[3], j3[BTN_START] | ks[2],
                           j2[BTN_START] | any[BTN_START2_ALT] | ks[1], j1[BTN_START] | ks[0]};
        r.coin = {3'b000, any[BTN_COIN] | (|kc)};
        r.pause_req = any[BTN_PAUSE] | kp;
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // One strobe, then hold off while the packer raises ioctl_wait
    task automatic send_byte(input dl_index_t idx, input int addr, input ioctl_byte_t data);
        int t;
        @(posedge clk_sys);
        ioctl_index <= idx;
        ioctl_addr  <= byte_addr_t'(addr);
        ioctl_dout  <= data;
        ioctl_wr    <= 1'b1;
        @(posedge clk_sys);
        ioctl_wr <= 1'b0;
        @(negedge clk_sys);
        t = 0;
        while (ioctl_wait && t < 100) begin
            @(negedge clk_sys);
            t++;
        end
        if (ioctl_wait) begin
            errors++;
            $display("ioctl_wait stayed high too long after byte at address %0d", addr);
        end
    endtask

    // CPU read data and channel ownership during the load
    always @(negedge clk_sys) begin
        if (!rst && sdr.req && sdr.rnw && load_busy) begin
            errors++;
            $display("CPU read reached the SDRAM channel while load_busy was high at %0t", $time);
        end
        if (!rst && cpu_rdy) begin
            check_val("cpu_dout", cpu_dout, ref_word(cpu_addr));
            reads_done++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int t;
        seed = 32'hc116;
        errors = 0;
        checks = 0;
        reads_done = 0;
        n_rom = 37;
        rst = 1'b1;
        ioctl_download = 1'b0;
        ioctl_index = '0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        cpu_addr = '0;
        cpu_req = 1'b0;
        {joy_p1, joy_p2, joy_p3, joy_p4} = '0;
        {key_p1, key_p2, key_p3, key_p4} = '0;
        key_start = '0;
        key_coin = '0;
        key_pause = 1'b0;
        for (int i = 0; i < 64; i++) rom_bytes[i] = $random(seed);
        for (int i = 0; i < 8; i++) dip_bytes[i] = $random(seed);
        repeat (8) @(posedge clk_sys);
        rst <= 1'b0;
        @(negedge clk_sys);
        check_val("sdr.req", sdr.req, 0);
        check_val("ioctl_wait", ioctl_wait, 0);
        check_val("load_busy", load_busy, 0);
        check_val("cpu_rdy", cpu_rdy, 0);
        check_val("dip_sw", dip_sw, 24'hffffff);
        for (int i = 0; i < 256; i++) init_mem[i] = sdram_model_inst.mem[i];

        // ROM download with stray bytes of another index
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        ioctl_index    <= ROM_INDEX;
        for (int i = 0; i < n_rom; i++) begin
            send_byte(ROM_INDEX, i, rom_bytes[i]);
            // A leaked stray byte would rewrite the word just completed
            if (i % 8 == 3) send_byte(8'd5, i, rom_bytes[i] ^ 8'hff);
            if (i == 10) begin
                @(posedge clk_sys);
                cpu_addr <= 24'd18;
                cpu_req  <= 1'b1;
            end
        end
        @(posedge clk_sys);
        ioctl_download <= 1'b0;
        t = 0;
        @(negedge clk_sys);
        while (load_busy && t < 200) begin
            @(negedge clk_sys);
            t++;
        end
        if (load_busy) begin
            errors++;
            $display("timeout waiting for load_busy to fall");
        end
        t = 0;
        while (!cpu_rdy && t < 200) begin
            @(negedge clk_sys);
            t++;
        end
        if (!cpu_rdy) begin
            errors++;
            $display("timeout waiting for cpu_rdy");
        end
        @(posedge clk_sys);
        cpu_req <= 1'b0;
        repeat (4) @(negedge clk_sys);
        check_val("cpu read count", reads_done, 1);
        check_val("sdram write count", sdram_model_inst.writes, (n_rom + 1) / 2);
        for (int w = 0; w < 32; w++) begin
            check_val($sformatf("sdram word[%0d]", w), sdram_model_inst.mem[w], ref_word(w));
        end

        // Eight DIP bytes and one out of range byte at address 8
        @(posedge clk_sys);
        ioctl_download <= 1'b1;
        for (int a = 0; a < 9; a++) begin
            send_byte(DIP_INDEX, a, (a == 8) ? dip_bytes[0] ^ 8'h3c : dip_bytes[a]);
        end
        @(posedge clk_sys);
        ioctl_download <= 1'b0;
        @(negedge clk_sys);
        check_val("dip_sw", dip_sw, {dip_bytes[2], dip_bytes[1], dip_bytes[0]});

        // Sparse random pads so that shared buttons toggle both ways
        for (int k = 0; k < 40; k++) begin
            @(posedge clk_sys);
            joy_p1 <= $random(seed) & $random(seed);
            joy_p2 <= $random(seed) & $random(seed);
            joy_p3 <= $random(seed) & $random(seed);
            joy_p4 <= $random(seed) & $random(seed);
            key_p1 <= $random(seed) & $random(seed);
            key_p2 <= $random(seed) & $random(seed);
            key_p3 <= $random(seed) & $random(seed);
            key_p4 <= $random(seed) & $random(seed);
            key_start <= $random(seed) & $random(seed);
            key_coin <= $random(seed) & $random(seed) & $random(seed);
            key_pause <= ($random(seed) & 7) == 0;
            @(negedge clk_sys);
            exp_in = ref_inputs(joy_p1, joy_p2, joy_p3, joy_p4, key_p1, key_p2, key_p3,
                                key_p4, key_start, key_coin, key_pause);
            check_val("p1_input", p1_input, exp_in.p1);
            check_val("p2_input", p2_input, exp_in.p2);
            check_val("p3_input", p3_input, exp_in.p3);
            check_val("p4_input", p4_input, exp_in.p4);
            check_val("start_buttons", start_buttons, exp_in.start_buttons);
            check_val("coin", coin, exp_in.coin);
            check_val("pause_req", pause_req, exp_in.pause_req);
        end

        repeat (2) @(posedge clk_sys);
        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== bench/sdram_model.sv ====
/* Behavioral SDRAM channel with a 256-word memory, byte enables
   and a random ready latency */
`timescale 1ns/10ps

module sdram_model import m92_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst,
    input  sdr_req_t  sdr,
    output logic      sdr_rdy,
    output sdr_word_t sdr_dout
);

    sdr_word_t   mem [256];
    int          seed;
    int          writes;
    logic        active;
    int unsigned count;

    // Fill pattern mixes every address bit into both bytes
    initial begin
        seed = 32'hc116;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (16'(i) * 16'h0101) ^ 16'h5a3c ^ {8'(i) << 3, 8'h00};
        end
    end

    always @(posedge clk_sys) begin
        if (rst) begin
            sdr_rdy <= 1'b0;
            active  <= 1'b0;
            writes  <= 0;
        end else if (sdr_rdy) begin
            // Request is still high in this cycle, the owner drops it next
            sdr_rdy <= 1'b0;
        end else if (active) begin
            if (count == 0) begin
                sdr_rdy <= 1'b1;
                active  <= 1'b0;
                if (sdr.rnw) begin
                    sdr_dout <= mem[sdr.addr[7:0]];
                end else begin
                    writes <= writes + 1;
                    if (sdr.be[0]) mem[sdr.addr[7:0]][7:0] <= sdr.din[7:0];
                    if (sdr.be[1]) mem[sdr.addr[7:0]][15:8] <= sdr.din[15:8];
                end
            end else begin
                count <= count - 1;
            end
        end else if (sdr.req) begin
            active <= 1'b1;
            count  <= $unsigned($random(seed)) % 4;
        end
    end

endmodule

// ==== source/m92_mem_ctrl.sv ====
/* Memory and control top, ROM loader and CPU on SDRAM channel 3,
   DIP switch capture and merged arcade inputs */
`timescale 1ns/10ps

module m92_mem_ctrl import m92_pkg::*; (
    input  logic                       clk_sys,
    input  logic                       rst,
    // Host download stream
    input  logic                       ioctl_download,
    input  dl_index_t                  ioctl_index,
    input  logic                       ioctl_wr,
    input  byte_addr_t                 ioctl_addr,
    input  ioctl_byte_t                ioctl_dout,
    output logic                       ioctl_wait,
    output logic                       load_busy,
    // CPU ROM port
    input  word_addr_t                 cpu_addr,
    input  logic                       cpu_req,
    output logic                       cpu_rdy,
    output sdr_word_t                  cpu_dout,
    // SDRAM channel 3
    output sdr_req_t                   sdr,
    input  logic                       sdr_rdy,
    input  sdr_word_t                  sdr_dout,
    output logic [DIP_OUT_BYTES*8-1:0] dip_sw,
    // Controls
    input  pad_t                       joy_p1,
    input  pad_t                       joy_p2,
    input  pad_t                       joy_p3,
    input  pad_t                       joy_p4,
    input  pad_t                       key_p1,
    input  pad_t                       key_p2,
    input  pad_t                       key_p3,
    input  pad_t                       key_p4,
    input  logic [3:0]                 key_start,
    input  logic [3:0]                 key_coin,
    input  logic                       key_pause,
    output player_t                    p1_input,
    output player_t                    p2_input,
    output player_t                    p3_input,
    output player_t                    p4_input,
    output logic [3:0]                 start_buttons,
    output logic [3:0]                 coin,
    output logic                       pause_req
);

    sdr_req_t loader_req;
    logic     loader_rdy;
    logic     cpu_req_arb;

    // CPU stays off the channel for the whole ROM load
    assign cpu_req_arb = cpu_req & ~load_busy;
    assign cpu_dout    = sdr_dout;

    rom_word_packer rom_word_packer_inst (
        .clk_sys, .rst,
        .ioctl_download, .ioctl_index, .ioctl_wr, .ioctl_addr, .ioctl_dout,
        .ioctl_wait, .loader_req, .loader_rdy, .load_busy
    );

    sdram_ch3_arbiter sdram_ch3_arbiter_inst (
        .clk_sys, .rst,
        .loader_req, .loader_rdy,
        .cpu_addr, .cpu_req(cpu_req_arb), .cpu_rdy,
        .sdr, .sdr_rdy
    );

    dip_switch_bank dip_switch_bank_inst (
        .clk_sys, .rst,
        .ioctl_wr, .ioctl_index, .ioctl_addr, .ioctl_dout, .dip_sw
    );

    arcade_inputs arcade_inputs_inst (
        .joy_p1, .joy_p2, .joy_p3, .joy_p4,
        .key_p1, .key_p2, .key_p3, .key_p4,
        .key_start, .key_coin, .key_pause,
        .p1_input, .p2_input, .p3_input, .p4_input,
        .start_buttons, .coin, .pause_req
    );

endmodule

// ==== source/arcade_inputs.sv ====
/* Player, start, coin and pause inputs merged from joystick
   and decoded keyboard vectors */
`timescale 1ns/10ps

module arcade_inputs import m92_pkg::*; (
    input  pad_t       joy_p1,
    input  pad_t       joy_p2,
    input  pad_t       joy_p3,
    input  pad_t       joy_p4,
    input  pad_t       key_p1,
    input  pad_t       key_p2,
    input  pad_t       key_p3,
    input  pad_t       key_p4,
    input  logic [3:0] key_start,
    input  logic [3:0] key_coin,
    input  logic       key_pause,
    output player_t    p1_input,
    output player_t    p2_input,
    output player_t    p3_input,
    output player_t    p4_input,
    output logic [3:0] start_buttons,
    output logic [3:0] coin,
    output logic       pause_req
);

    pad_t merged_p1;
    pad_t merged_p2;
    pad_t merged_p3;
    pad_t merged_p4;
    pad_t joy_any;

    assign merged_p1 = joy_p1 | key_p1;
    assign merged_p2 = joy_p2 | key_p2;
    assign merged_p3 = joy_p3 | key_p3;
    assign merged_p4 = joy_p4 | key_p4;

    // Shared buttons respond to any pad
    assign joy_any = joy_p1 | joy_p2 | joy_p3 | joy_p4;

    assign p1_input = merged_p1[9:0];
    assign p2_input = merged_p2[9:0];
    assign p3_input = merged_p3[9:0];
    assign p4_input = merged_p4[9:0];

    assign start_buttons[0] = joy_p1[BTN_START] | key_start[0];
    // Second start also on a dedicated button of any pad
    assign start_buttons[1] = joy_p2[BTN_START] | joy_any[BTN_START2_ALT] | key_start[1];
    assign start_buttons[2] = joy_p3[BTN_START] | key_start[2];
    assign start_buttons[3] = joy_p4[BTN_START] | key_start[3];

    // Single coin slot
    assign coin      = {3'b000, joy_any[BTN_COIN] | (|key_coin)};
    assign pause_req = joy_any[BTN_PAUSE] | key_pause;

endmodule

// ==== source/dip_switch_bank.sv ====
/* DIP switch bytes captured from the download stream */
`timescale 1ns/10ps

module dip_switch_bank import m92_pkg::*; (
    input  logic                       clk_sys,
    input  logic                       rst,
    input  logic                       ioctl_wr,
    input  dl_index_t                  ioctl_index,
    input  byte_addr_t                 ioctl_addr,
    input  ioctl_byte_t                ioctl_dout,
    output logic [DIP_OUT_BYTES*8-1:0] dip_sw
);

    // Switches are active low, all ones means every switch off
    ioctl_byte_t dip_q [DIP_COUNT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < DIP_COUNT; i++) begin
                dip_q[i] <= 8'hff;
            end
        end else if (ioctl_wr && (ioctl_index == DIP_INDEX) &&
                     (ioctl_addr < byte_addr_t'(DIP_COUNT))) begin
            dip_q[ioctl_addr[2:0]] <= ioctl_dout;
        end
    end

    // Upper bytes are kept but the board only reads the low three
    for (genvar g = 0; g < DIP_OUT_BYTES; g++) begin : g_dip_out
        assign dip_sw[g*8 +: 8] = dip_q[g];
    end

endmodule

// ==== source/sdram_ch3_arbiter.sv ====
/* Channel 3 arbiter, shares one SDRAM channel between the ROM loader
   and CPU reads with loader priority */
`timescale 1ns/10ps

module sdram_ch3_arbiter import m92_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst,
    input  sdr_req_t   loader_req,
    output logic       loader_rdy,
    input  word_addr_t cpu_addr,
    input  logic       cpu_req,
    output logic       cpu_rdy,
    output sdr_req_t   sdr,
    input  logic       sdr_rdy
);

    arb_owner_t owner;

    ////////////////////////////////////////////////////////////////////////////
    // Owner FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            owner <= OWN_IDLE;
        end else begin
            case (owner)
                OWN_IDLE: begin
                    // Loader wins whenever both are asking
                    if (loader_req.req) begin
                        owner <= OWN_LOADER;
                    end else if (cpu_req) begin
                        owner <= OWN_CPU;
                    end
                end
                default: begin
                    if (sdr_rdy) begin
                        owner <= OWN_IDLE;
                    end
                end
            endcase
        end
    end

    // Channel mux, CPU accesses are always word reads
    always_comb begin
        case (owner)
            OWN_LOADER: sdr = loader_req;
            OWN_CPU: begin
                sdr.addr = cpu_addr;
                sdr.din  = '0;
                sdr.be   = 2'b00;
                sdr.rnw  = 1'b1;
                // held until the ready pulse ends the access
                sdr.req  = 1'b1;
            end
            default: sdr = '0;
        endcase
    end

    assign loader_rdy = (owner == OWN_LOADER) && sdr_rdy;
    assign cpu_rdy    = (owner == OWN_CPU) && sdr_rdy;

endmodule

// ==== source/rom_word_packer.sv ====
/* ROM download packer, pairs bytes into 16-bit SDRAM word writes
   and flushes a trailing lone byte at the end of the download */
`timescale 1ns/10ps

module rom_word_packer import m92_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst,
    input  logic        ioctl_download,
    input  dl_index_t   ioctl_index,
    input  logic        ioctl_wr,
    input  byte_addr_t  ioctl_addr,
    input  ioctl_byte_t ioctl_dout,
    output logic        ioctl_wait,
    output sdr_req_t    loader_req,
    input  logic        loader_rdy,
    output logic        load_busy
);

    logic        req_q;
    logic        wait_q;
    logic        lo_valid;
    logic        rom_active;
    ioctl_byte_t lo_byte;
    word_addr_t  lo_addr;
    word_addr_t  addr_q;
    sdr_word_t   din_q;
    sdr_be_t     be_q;
    logic        rom_wr;
    logic        dl_end;

    assign rom_wr = ioctl_wr && ioctl_download && (ioctl_index == ROM_INDEX);
    // Falling edge of a download that carried the ROM image
    assign dl_end = rom_active && !ioctl_download;

    // Active from the first cycle with the ROM index until the download drops
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rom_active <= 1'b0;
        end else if (!ioctl_download) begin
            rom_active <= 1'b0;
        end else if (ioctl_index == ROM_INDEX) begin
            rom_active <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Request control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            req_q    <= 1'b0;
            wait_q   <= 1'b0;
            lo_valid <= 1'b0;
        end else if (req_q) begin
            // Fields stay frozen until the channel answers
            if (loader_rdy) begin
                req_q  <= 1'b0;
                wait_q <= 1'b0;
            end
        end else if (rom_wr && ioctl_addr[0]) begin
            req_q    <= 1'b1;
            wait_q   <= 1'b1;
            lo_valid <= 1'b0;
        end else if (rom_wr) begin
            lo_valid <= 1'b1;
        end else if (dl_end && lo_valid) begin
            req_q    <= 1'b1;
            lo_valid <= 1'b0;
        end
    end

    // Payload follows the same priority as the control above
    always_ff @(posedge clk_sys) begin
        if (!req_q) begin
            if (rom_wr && ioctl_addr[0]) begin
                addr_q <= ioctl_addr[24:1];
                din_q  <= {ioctl_dout, lo_byte};
                be_q   <= 2'b11;
            end else if (rom_wr) begin
                lo_byte <= ioctl_dout;
                lo_addr <= ioctl_addr[24:1];
            end else if (dl_end && lo_valid) begin
                addr_q <= lo_addr;
                din_q  <= {8'h00, lo_byte};
                be_q   <= 2'b01;
            end
        end
    end

    assign loader_req.addr = addr_q;
    assign loader_req.din  = din_q;
    assign loader_req.be   = be_q;
    assign loader_req.rnw  = 1'b0;
    assign loader_req.req  = req_q;

    assign ioctl_wait = wait_q;
    // Covers the flush write issued after the download has ended
    assign load_busy  = rom_active | req_q;

endmodule

// ==== source/m92_pkg.sv ====
/* Shared widths, vector types, download indexes, joystick bit positions,
   the SDRAM channel request struct and the arbiter owner enum */
package m92_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    // Byte address from the host download stream
    typedef logic [24:0] byte_addr_t;
    // SDRAM addresses 16-bit words, so bit 0 of the byte address is dropped
    typedef logic [23:0] word_addr_t;
    typedef logic [15:0] sdr_word_t;
    // Bit 0 enables the low byte
    typedef logic [1:0]  sdr_be_t;
    typedef logic [7:0]  ioctl_byte_t;
    typedef logic [7:0]  dl_index_t;
    typedef logic [9:0]  player_t;
    typedef logic [15:0] pad_t;

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam dl_index_t ROM_INDEX = 8'd0;
    localparam dl_index_t DIP_INDEX = 8'd254;

    localparam int DIP_COUNT     = 8;
    // Only the first three DIP bytes go to the board
    localparam int DIP_OUT_BYTES = 3;

    // Joystick bit positions above the ten player bits
    localparam int BTN_START      = 10;
    localparam int BTN_COIN       = 11;
    localparam int BTN_START2_ALT = 12;
    localparam int BTN_PAUSE      = 13;

    // One request on the shared SDRAM channel
    typedef struct packed {
        word_addr_t addr;
        sdr_word_t  din;
        sdr_be_t    be;
        logic       rnw;
        logic       req;
    } sdr_req_t;

    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_LOADER,
        OWN_CPU
    } arb_owner_t;

endpackage
